//--- bench/tb_dhcp_client.sv
`timescale 1ns/1ps
`include "dhcp_settings.svh"

module tb_dhcp_client;
    import dhcp_pkg::*;

    localparam int LIMIT = 2000;
    localparam int ROWS = 6;

    localparam int F_EE_READY = 0;
    localparam int F_EE_DONE = 1;
    localparam int F_MSG_DONE = 2;
    localparam int F_OFFER_READY = 3;
    localparam int F_OFFER_DONE = 4;

    // one answer frame and what it should do
    typedef struct packed {
        logic       has_mask;
        logic       has_router;
        logic       has_server;
        logic [7:0] msg_type;
        logic [1:0] corrupt;       // 1 bad op, 2 bad xid
        logic       exp_commit;
        logic       exp_received;
    } offer_case_t;

    logic        clk;
    logic        rst;
    logic        eeprom_start;
    logic        eeprom_done;
    logic [7:0]  eeprom_data;
    logic        eeprom_valid;
    logic        eeprom_ready;
    logic        msg_start;
    logic        msg_is_discover;
    logic        msg_done;
    byte_beat_t  msg_beat;
    logic        msg_valid;
    logic        msg_ready;
    logic        offer_start;
    logic        offer_done;
    byte_beat_t  offer_beat;
    logic        offer_valid;
    logic        offer_ready;
    net_params_t net;
    logic        offer_received;

    offer_case_t cases [ROWS];
    integer      seed;
    int          errors;
    int          checks;
    logic        timed_out;
    logic [7:0]  ee_bytes [`DHCP_EEPROM_BYTES];
    logic [7:0]  got_q [$];
    logic [7:0]  model_q [$];
    net_params_t exp_net;
    logic [31:0] disc_xid;
    logic [31:0] off_ip;
    logic [31:0] off_router;
    logic [31:0] off_mask;
    logic [31:0] off_server;

    dhcp_client_core dut (.*);

    always #2 clk = ~clk;

    function automatic logic status_flag(input int which);
        case (which)
            F_EE_READY:    return eeprom_ready;
            F_EE_DONE:     return eeprom_done;
            F_MSG_DONE:    return msg_done;
            F_OFFER_READY: return offer_ready;
            default:       return offer_done;
        endcase
    endfunction

    task automatic note_timeout(input string what);
        if (!timed_out)
            $display("timeout: gave up waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // returns 1 ns after the edge that follows the level being seen
    task automatic wait_level(input int which, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (status_flag(which) !== level && !timed_out)
        begin
            @(negedge clk);
            n++;
            if (n > LIMIT)
                note_timeout(what);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_frame(input logic [7:0] op);
        model_q.delete();
        for (int i = 0; i <= `DHCP_HDR_LAST; i++)
            model_q.push_back(8'h00);
        model_q[0]     = op;
        model_q[1]     = 8'h01;
        model_q[2]     = 8'h06;
        model_q[8'hEC] = 8'h63;
        model_q[8'hED] = 8'h82;
        model_q[8'hEE] = 8'h53;
        model_q[8'hEF] = 8'h63;
    endtask

    task automatic append_option(input logic [7:0] code, input logic [31:0] word);
        model_q.push_back(code);
        model_q.push_back(8'd4);
        for (int i = 0; i < 4; i++)
            model_q.push_back(word[31 - 8 * i -: 8]);
    endtask

    task automatic build_msg_model(input logic discover);
        start_frame(8'h01);
        for (int i = 0; i < 4; i++)
        begin
            model_q[4 + i]  = disc_xid[31 - 8 * i -: 8];
            model_q[12 + i] = discover ? exp_net.ip[31 - 8 * i -: 8] : 8'h00;
        end
        for (int i = 0; i < 6; i++)
            model_q[28 + i] = exp_net.mac[47 - 8 * i -: 8];
        model_q.push_back(`DHCP_OPT_MSG_TYPE);
        model_q.push_back(8'd1);
        model_q.push_back(discover ? 8'd1 : 8'd3);
        if (!discover && cases[ROWS - 1].has_router)
            append_option(`DHCP_OPT_ROUTER, off_router);
        append_option(`DHCP_OPT_REQ_IP, discover ? exp_net.ip : off_ip);
        if (!discover && cases[ROWS - 1].has_server)
            append_option(`DHCP_OPT_SERVER_ID, off_server);
        model_q.push_back(`DHCP_OPT_END);
        repeat (`DHCP_TERM_BYTES - 1)
            model_q.push_back(8'h00);
    endtask

    task automatic build_offer(input offer_case_t c);
        logic [31:0] x;
        x = (c.corrupt == 2'd2) ? ~disc_xid : disc_xid;
        start_frame((c.corrupt == 2'd1) ? 8'h01 : 8'h02);
        for (int i = 0; i < 4; i++)
        begin
            model_q[4 + i]  = x[31 - 8 * i -: 8];
            model_q[16 + i] = off_ip[31 - 8 * i -: 8];
        end
        model_q.push_back(`DHCP_OPT_MSG_TYPE);
        model_q.push_back(8'd1);
        model_q.push_back(c.msg_type);
        if (c.has_mask)
            append_option(`DHCP_OPT_MASK, off_mask);
        if (c.has_router)
            append_option(`DHCP_OPT_ROUTER, off_router);
        if (c.has_server)
            append_option(`DHCP_OPT_SERVER_ID, off_server);
        model_q.push_back(`DHCP_OPT_END);
    endtask

    task automatic load_eeprom();
        for (int i = 0; i < `DHCP_EEPROM_BYTES; i++)
            ee_bytes[i] = 8'($random(seed));
        eeprom_start = 1'b1;
        for (int i = 0; i < `DHCP_EEPROM_BYTES; i++)
        begin
            eeprom_data  = ee_bytes[i];
            eeprom_valid = 1'b1;
            wait_level(F_EE_READY, 1'b1, "eeprom_ready");
        end
        eeprom_valid = 1'b0;
        wait_level(F_EE_DONE, 1'b1, "eeprom_done");
        exp_net.mac     = {ee_bytes[0], ee_bytes[1], ee_bytes[2],
                           ee_bytes[3], ee_bytes[4], ee_bytes[5]};
        exp_net.ip      = {ee_bytes[6], ee_bytes[7], ee_bytes[8], ee_bytes[9]};
        exp_net.gateway = {ee_bytes[10], ee_bytes[11], ee_bytes[12], ee_bytes[13]};
        exp_net.mask    = {ee_bytes[14], ee_bytes[15], ee_bytes[16], ee_bytes[17]};
        check_val("eeprom net.mac", net.mac, exp_net.mac);
        check_val("eeprom net.ip", net.ip, exp_net.ip);
        check_val("eeprom net.gateway", net.gateway, exp_net.gateway);
        check_val("eeprom net.mask", net.mask, exp_net.mask);
        repeat (3) @(posedge clk);
        #1;
        check_val("eeprom_done with start held", eeprom_done, 1'b1);
        eeprom_start = 1'b0;
        wait_level(F_EE_DONE, 1'b0, "eeprom_done to fall");
    endtask

    task automatic capture_msg(input logic discover);
        int   n;
        logic seen_last;
        got_q.delete();
        n = 0;
        seen_last = 1'b0;
        msg_is_discover = discover;
        msg_start = 1'b1;
        while (!seen_last && !timed_out)
        begin
            // roughly one stall in four
            msg_ready = ($random(seed) % 4) != 0;
            @(negedge clk);
            if (msg_valid && msg_ready)
            begin
                got_q.push_back(msg_beat.data);
                seen_last = msg_beat.last;
            end
            @(posedge clk);
            #1;
            n++;
            if (n > LIMIT)
                note_timeout("the last message beat");
        end
        msg_ready = 1'b0;
        wait_level(F_MSG_DONE, 1'b1, "msg_done");
        msg_start = 1'b0;
        wait_level(F_MSG_DONE, 1'b0, "msg_done to fall");
    endtask

    task automatic compare_msg(input string name);
        check_val({name, " length"}, got_q.size(), model_q.size());
        for (int i = 0; i < model_q.size() && i < got_q.size(); i++)
            check_val($sformatf("%s byte %0d", name, i), got_q[i], model_q[i]);
    endtask

    task automatic run_offer_case(input int r);
        offer_case_t c;
        c = cases[r];
        off_ip     = $random(seed);
        off_router = $random(seed);
        off_mask   = $random(seed);
        off_server = $random(seed);
        build_offer(c);
        offer_start = 1'b1;
        for (int i = 0; i < model_q.size(); i++)
        begin
            offer_beat.data = model_q[i];
            offer_beat.last = (i == model_q.size() - 1);
            offer_valid     = 1'b1;
            wait_level(F_OFFER_READY, 1'b1, "offer_ready");
        end
        offer_valid = 1'b0;
        offer_beat  = '0;
        wait_level(F_OFFER_DONE, 1'b1, "offer_done");
        if (c.exp_commit)
        begin
            exp_net.ip      = off_ip;
            exp_net.gateway = c.has_router ? off_router : off_server;
            if (c.has_mask)
                exp_net.mask = off_mask;
        end
        check_val($sformatf("row %0d offer_received", r), offer_received, c.exp_received);
        check_val($sformatf("row %0d net.mac", r), net.mac, exp_net.mac);
        check_val($sformatf("row %0d net.ip", r), net.ip, exp_net.ip);
        check_val($sformatf("row %0d net.gateway", r), net.gateway, exp_net.gateway);
        check_val($sformatf("row %0d net.mask", r), net.mask, exp_net.mask);
        offer_start = 1'b0;
        wait_level(F_OFFER_DONE, 1'b0, "offer_done to fall");
    endtask

    initial
    begin
        seed            = 44;
        errors          = 0;
        checks          = 0;
        timed_out       = 1'b0;
        clk             = 1'b0;
        rst             = 1'b1;
        eeprom_start    = 1'b0;
        eeprom_data     = 8'h00;
        eeprom_valid    = 1'b0;
        msg_start       = 1'b0;
        msg_is_discover = 1'b0;
        msg_ready       = 1'b0;
        offer_start     = 1'b0;
        offer_beat      = '0;
        offer_valid     = 1'b0;
        disc_xid        = '0;

        // mask router server type corrupt commit received
        cases[0] = {1'b1, 1'b1, 1'b1, `DHCP_MSG_OFFER, 2'd0, 1'b1, 1'b1};
        cases[1] = {1'b1, 1'b1, 1'b1, `DHCP_MSG_OFFER, 2'd2, 1'b0, 1'b1};
        cases[2] = {1'b1, 1'b1, 1'b1, `DHCP_MSG_OFFER, 2'd1, 1'b0, 1'b1};
        // parser holds an uncommitted mask from here on
        cases[3] = {1'b1, 1'b0, 1'b0, 8'd5, 2'd0, 1'b0, 1'b0};
        cases[4] = {1'b0, 1'b0, 1'b1, `DHCP_MSG_OFFER, 2'd0, 1'b1, 1'b1};
        cases[5] = {1'b1, 1'b1, 1'b1, `DHCP_MSG_OFFER, 2'd0, 1'b1, 1'b1};

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val("status outputs after reset",
                  {eeprom_ready, eeprom_done, msg_valid, msg_done,
                   offer_ready, offer_done, offer_received}, 7'd0);

        load_eeprom();

        capture_msg(1'b1);
        if (got_q.size() >= 8)
            disc_xid = {got_q[4], got_q[5], got_q[6], got_q[7]};
        build_msg_model(1'b1);
        compare_msg("DISCOVER");

        for (int r = 0; r < ROWS && !timed_out; r++)
            run_offer_case(r);

        capture_msg(1'b0);
        build_msg_model(1'b0);
        compare_msg("REQUEST");

        $display("checks: %0d  errors: %0d  timed out: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- logic/dhcp_client_core.sv
`timescale 1ns/1ps

module dhcp_client_core
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  eeprom_start,
    output logic                  eeprom_done,
    input  logic [7:0]            eeprom_data,
    input  logic                  eeprom_valid,
    output logic                  eeprom_ready,
    input  logic                  msg_start,
    input  logic                  msg_is_discover,
    output logic                  msg_done,
    output dhcp_pkg::byte_beat_t  msg_beat,
    output logic                  msg_valid,
    input  logic                  msg_ready,
    input  logic                  offer_start,
    output logic                  offer_done,
    input  dhcp_pkg::byte_beat_t  offer_beat,
    input  logic                  offer_valid,
    output logic                  offer_ready,
    output dhcp_pkg::net_params_t net,
    output logic                  offer_received
);
    import dhcp_pkg::*;

    offer_info_t offer;
    logic        commit;
    logic [31:0] xid;

    net_config_regs u_regs
    (
        .clk          (clk),
        .rst          (rst),
        .eeprom_start (eeprom_start),
        .eeprom_data  (eeprom_data),
        .eeprom_valid (eeprom_valid),
        .eeprom_ready (eeprom_ready),
        .eeprom_done  (eeprom_done),
        .commit       (commit),
        .offer        (offer),
        .net          (net)
    );

    dhcp_msg_builder u_builder
    (
        .clk             (clk),
        .rst             (rst),
        .msg_start       (msg_start),
        .msg_is_discover (msg_is_discover),
        .msg_done        (msg_done),
        .net             (net),
        .offer           (offer),
        .msg_beat        (msg_beat),
        .msg_valid       (msg_valid),
        .msg_ready       (msg_ready),
        .xid             (xid)
    );

    // checks answers against the xid of the last discover
    dhcp_offer_parser u_parser
    (
        .clk            (clk),
        .rst            (rst),
        .offer_start    (offer_start),
        .offer_done     (offer_done),
        .offer_beat     (offer_beat),
        .offer_valid    (offer_valid),
        .offer_ready    (offer_ready),
        .xid            (xid),
        .offer          (offer),
        .commit         (commit),
        .offer_received (offer_received)
    );

endmodule

//--- logic/dhcp_msg_builder.sv
`timescale 1ns/1ps
`include "dhcp_settings.svh"

module dhcp_msg_builder
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  msg_start,
    input  logic                  msg_is_discover,
    output logic                  msg_done,
    input  dhcp_pkg::net_params_t net,
    input  dhcp_pkg::offer_info_t offer,
    output dhcp_pkg::byte_beat_t  msg_beat,
    output logic                  msg_valid,
    input  logic                  msg_ready,
    output logic [31:0]           xid
);
    import dhcp_pkg::*;

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef enum logic [2:0] {
        S_IDLE, S_HDR, S_ROUTER, S_REQ_IP, S_SERVER, S_TERM, S_DONE
    } sec_t;

    sec_t        sec;
    sec_t        next_sec;
    logic [7:0]  idx;
    logic        is_discover;
    logic [31:0] lfsr;
    logic        xfer;
    logic        sec_end;
    logic [1:0]  opt_k;
    logic [7:0]  opt_code;
    logic [31:0] opt_word;

    assign msg_valid = (sec != S_IDLE) && (sec != S_DONE);
    assign msg_done  = (sec == S_DONE);
    assign xfer      = msg_valid && msg_ready;
    assign opt_k     = idx[1:0] - 2'd2;

    always_comb
    begin
        case (sec)
            S_HDR:   sec_end = (idx == `DHCP_OPT53_LAST);
            S_TERM:  sec_end = (idx == 8'(`DHCP_TERM_BYTES - 1));
            default: sec_end = (idx == 8'd5);
        endcase
    end

    // router and server id only go out in a request that has them
    always_comb
    begin
        case (sec)
            S_HDR:
                next_sec = (!is_discover && offer.gateway_valid) ? S_ROUTER : S_REQ_IP;
            S_ROUTER:
                next_sec = S_REQ_IP;
            S_REQ_IP:
                next_sec = (!is_discover && offer.server_valid) ? S_SERVER : S_TERM;
            S_SERVER:
                next_sec = S_TERM;
            default:
                next_sec = S_DONE;
        endcase
    end

    always_comb
    begin
        case (sec)
            S_ROUTER:
            begin
                opt_code = `DHCP_OPT_ROUTER;
                opt_word = offer.gateway;
            end
            S_SERVER:
            begin
                opt_code = `DHCP_OPT_SERVER_ID;
                opt_word = offer.server_id;
            end
            default:
            begin
                opt_code = `DHCP_OPT_REQ_IP;
                opt_word = is_discover ? net.ip : offer.offered_ip;
            end
        endcase
    end

    always_comb
    begin
        msg_beat.last = (sec == S_TERM) && sec_end;
        msg_beat.data = 8'h00;
        if (sec == S_HDR)
        begin
            case (idx) inside
                8'h00, 8'h01:  msg_beat.data = 8'h01;
                8'h02:         msg_beat.data = 8'h06;
                [8'h04:8'h07]: msg_beat.data = word_byte(xid, idx[1:0]);
                [8'h0C:8'h0F]: msg_beat.data = is_discover ? word_byte(net.ip, idx[1:0]) : 8'h00;
                [8'h1C:8'h21]: msg_beat.data = net.mac[8 * (8'h21 - idx) +: 8];
                // magic cookie
                8'hEC, 8'hEF:  msg_beat.data = 8'h63;
                8'hED:         msg_beat.data = 8'h82;
                8'hEE:         msg_beat.data = 8'h53;
                8'hF0:         msg_beat.data = `DHCP_OPT_MSG_TYPE;
                8'hF1:         msg_beat.data = 8'h01;
                8'hF2:         msg_beat.data = is_discover ? 8'd1 : 8'd3;
                default:       msg_beat.data = 8'h00;
            endcase
        end
        else if (sec == S_TERM)
            msg_beat.data = (idx == 8'd0) ? `DHCP_OPT_END : 8'h00;
        else if (msg_valid)
        begin
            case (idx)
                8'd0:    msg_beat.data = opt_code;
                8'd1:    msg_beat.data = 8'd4;
                default: msg_beat.data = word_byte(opt_word, opt_k);
            endcase
        end
    end

    // free running, sampled when a discover starts
    always_ff @(posedge clk)
    begin
        if (rst)
            lfsr <= `DHCP_XID_SEED;
        else
            lfsr <= (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sec <= S_IDLE;
            idx <= '0;
        end
        else
        begin
            case (sec)
                S_IDLE:
                    if (msg_start)
                    begin
                        sec         <= S_HDR;
                        idx         <= '0;
                        is_discover <= msg_is_discover;
                        if (msg_is_discover)
                            xid <= lfsr;
                    end
                S_DONE:
                    if (!msg_start)
                        sec <= S_IDLE;
                default:
                    if (xfer)
                    begin
                        idx <= sec_end ? 8'd0 : idx + 8'd1;
                        if (sec_end)
                            sec <= next_sec;
                    end
            endcase
        end
    end

endmodule

//--- logic/dhcp_offer_parser.sv
`timescale 1ns/1ps
`include "dhcp_settings.svh"

module dhcp_offer_parser
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  offer_start,
    output logic                  offer_done,
    input  dhcp_pkg::byte_beat_t  offer_beat,
    input  logic                  offer_valid,
    output logic                  offer_ready,
    input  logic [31:0]           xid,
    output dhcp_pkg::offer_info_t offer,
    output logic                  commit,
    output logic                  offer_received
);
    import dhcp_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE, P_HDR, P_OPT_ID, P_OPT_LEN, P_OPT_DATA, P_LATCH, P_DRAIN, P_DONE
    } state_t;

    state_t      state;
    offer_info_t info;
    logic [7:0]  ptr;
    logic [7:0]  opt_id;
    logic [7:0]  opt_len;
    logic [31:0] opt_data;
    logic [31:0] opt_word;
    logic        take;
    logic        hdr_bad;

    assign offer_ready = state inside {P_HDR, P_OPT_ID, P_OPT_LEN, P_OPT_DATA, P_DRAIN};
    assign offer_done  = (state == P_DONE);
    assign commit      = (state == P_LATCH) && (info.gateway_valid || info.server_valid);
    assign take        = offer_valid && offer_ready;
    assign opt_word    = {opt_data[23:0], offer_beat.data};

    // op must be a reply and the xid ours
    always_comb
    begin
        case (ptr) inside
            8'h00:         hdr_bad = (offer_beat.data != 8'h02);
            8'h01:         hdr_bad = (offer_beat.data != 8'h01);
            8'h02:         hdr_bad = (offer_beat.data != 8'h06);
            [8'h04:8'h07]: hdr_bad = (offer_beat.data != word_byte(xid, ptr[1:0]));
            default:       hdr_bad = 1'b0;
        endcase
    end

    // no router option, so route through the server
    always_comb
    begin
        offer = info;
        if (!info.gateway_valid)
            offer.gateway = info.server_id;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state              <= P_IDLE;
            offer_received     <= 1'b0;
            info.gateway_valid <= 1'b0;
            info.mask_valid    <= 1'b0;
            info.server_valid  <= 1'b0;
        end
        else
        begin
            case (state)
                P_IDLE:
                    if (offer_start)
                    begin
                        ptr                <= '0;
                        info.gateway_valid <= 1'b0;
                        info.mask_valid    <= 1'b0;
                        info.server_valid  <= 1'b0;
                        state              <= P_HDR;
                    end
                P_HDR:
                    if (take)
                    begin
                        ptr <= ptr + 8'd1;
                        // yiaddr at 0x10..0x13
                        if (ptr[7:2] == 6'd4)
                            info.offered_ip <= {info.offered_ip[23:0], offer_beat.data};
                        if (offer_beat.last)
                            state <= P_LATCH;
                        else if (hdr_bad)
                            state <= P_DRAIN;
                        else if (ptr == `DHCP_HDR_LAST)
                            state <= P_OPT_ID;
                    end
                P_OPT_ID:
                    if (take)
                    begin
                        opt_id <= offer_beat.data;
                        if (offer_beat.last || offer_beat.data == `DHCP_OPT_END)
                            state <= P_LATCH;
                        else
                            state <= P_OPT_LEN;
                    end
                P_OPT_LEN:
                    if (take)
                    begin
                        opt_len <= offer_beat.data;
                        if (offer_beat.last)
                            state <= P_LATCH;
                        else if (offer_beat.data == 8'd0)
                            state <= P_OPT_ID;
                        else
                            state <= P_OPT_DATA;
                    end
                P_OPT_DATA:
                    if (take)
                    begin
                        opt_data <= opt_word;
                        opt_len  <= opt_len - 8'd1;
                        // last data byte of the option
                        if (opt_len == 8'd1)
                        begin
                            case (opt_id)
                                `DHCP_OPT_MASK:
                                begin
                                    info.mask       <= opt_word;
                                    info.mask_valid <= 1'b1;
                                end
                                `DHCP_OPT_ROUTER:
                                begin
                                    info.gateway       <= opt_word;
                                    info.gateway_valid <= 1'b1;
                                end
                                `DHCP_OPT_SERVER_ID:
                                begin
                                    info.server_id    <= opt_word;
                                    info.server_valid <= 1'b1;
                                end
                                `DHCP_OPT_MSG_TYPE:
                                    offer_received <= (offer_beat.data == `DHCP_MSG_OFFER);
                                default:
                                    ;
                            endcase
                        end
                        if (offer_beat.last)
                            state <= P_LATCH;
                        else if (opt_len == 8'd1)
                            state <= P_OPT_ID;
                    end
                P_LATCH:
                    state <= P_DONE;
                P_DRAIN:
                    if (take && offer_beat.last)
                        state <= P_DONE;
                default:
                    if (!offer_start)
                        state <= P_IDLE;
            endcase
        end
    end

endmodule

//--- logic/dhcp_pkg.sv
package dhcp_pkg;

    // field order matches the eeprom record
    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [31:0] gateway;
        logic [31:0] mask;
    } net_params_t;

    // what the last answer carried
    typedef struct packed {
        logic [31:0] offered_ip;
        logic [31:0] gateway;
        logic [31:0] mask;
        logic [31:0] server_id;
        logic        gateway_valid;
        logic        mask_valid;
        logic        server_valid;
    } offer_info_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    // byte k of a word, k = 0 is the most significant
    function automatic logic [7:0] word_byte(input logic [31:0] w, input logic [1:0] k);
        return w[{~k, 3'b000} +: 8];
    endfunction

endpackage

//--- logic/dhcp_settings.svh
`ifndef DHCP_SETTINGS_SVH
`define DHCP_SETTINGS_SVH

// eeprom record is 6 mac, 4 ip, 4 gateway, 4 mask
`define DHCP_EEPROM_BYTES 18

// bootp header and cookie end here
`define DHCP_HDR_LAST 8'hEF
`define DHCP_OPT53_LAST 8'hF2

// end option and four pad bytes
`define DHCP_TERM_BYTES 5

`define DHCP_OPT_MASK 8'd1
`define DHCP_OPT_ROUTER 8'd3
`define DHCP_OPT_REQ_IP 8'd50
`define DHCP_OPT_MSG_TYPE 8'd53
`define DHCP_OPT_SERVER_ID 8'd54
`define DHCP_OPT_END 8'd255

`define DHCP_MSG_OFFER 8'd2

// any nonzero word works
`define DHCP_XID_SEED 32'h1D3A_5C97

`endif

//--- logic/net_config_regs.sv
`timescale 1ns/1ps
`include "dhcp_settings.svh"

module net_config_regs
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  eeprom_start,
    input  logic [7:0]            eeprom_data,
    input  logic                  eeprom_valid,
    output logic                  eeprom_ready,
    output logic                  eeprom_done,
    input  logic                  commit,
    input  dhcp_pkg::offer_info_t offer,
    output dhcp_pkg::net_params_t net
);

    typedef enum logic [1:0] {L_IDLE, L_LOAD, L_DONE} load_state_t;

    load_state_t state;
    logic [4:0]  count;
    logic        take;

    assign take = eeprom_valid && eeprom_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= L_IDLE;
            eeprom_ready <= 1'b0;
            eeprom_done  <= 1'b0;
        end
        else
        begin
            case (state)
                L_IDLE:
                    if (eeprom_start)
                    begin
                        count        <= '0;
                        eeprom_ready <= 1'b1;
                        state        <= L_LOAD;
                    end
                L_LOAD:
                    if (take)
                    begin
                        count <= count + 5'd1;
                        if (count == 5'(`DHCP_EEPROM_BYTES - 1))
                        begin
                            eeprom_ready <= 1'b0;
                            eeprom_done  <= 1'b1;
                            state        <= L_DONE;
                        end
                    end
                default:
                    if (!eeprom_start)
                    begin
                        eeprom_done <= 1'b0;
                        state       <= L_IDLE;
                    end
            endcase
        end
    end

    // bytes shift in msb first through mac, ip, gateway and mask
    always_ff @(posedge clk)
    begin
        if (take)
            net <= {net[$bits(net)-9:0], eeprom_data};
        else if (commit)
        begin
            net.ip      <= offer.offered_ip;
            net.gateway <= offer.gateway;
            // keep the old mask unless the server sent one
            if (offer.mask_valid)
                net.mask <= offer.mask;
        end
    end

endmodule

//--- project.f
+incdir+logic
logic/dhcp_pkg.sv
logic/net_config_regs.sv
logic/dhcp_msg_builder.sv
logic/dhcp_offer_parser.sv
logic/dhcp_client_core.sv
bench/tb_dhcp_client.sv
